/* issue_core.f */
hw/issue_pkg.sv
hw/issue_queue.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/result_arbiter.sv
hw/issue_core.sv
testbench/tb_issue_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps --Mdir obj_dir
TOP      = tb_issue_core
FILELIST = issue_core.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* testbench/tb_issue_core.sv */
`timescale 1ns/1ps

module tb_issue_core;
    import issue_pkg::*;

    localparam int clk_period   = 20;
    localparam int num_tags     = 1 << tag_w;
    localparam int alu_ops      = 24;
    localparam int mul_ops      = 12;
    localparam int chain_ops    = 8;
    localparam int full_ops     = 6;
    localparam int mix_ops      = 40;
    localparam int total_ops    = alu_ops + mul_ops + chain_ops + full_ops + mix_ops;
    localparam int limit_cycles = total_ops * 20 + 200;

    logic              clk;
    logic              rst;
    logic              disp_valid;
    op_e               disp_op;
    logic [tag_w-1:0]  disp_tag;
    logic              disp_src1_ready;
    logic [tag_w-1:0]  disp_src1_tag;
    logic [data_w-1:0] disp_src1_data;
    logic              disp_src2_ready;
    logic [tag_w-1:0]  disp_src2_tag;
    logic [data_w-1:0] disp_src2_data;
    logic              disp_full;
    logic              bcast_valid;
    logic [tag_w-1:0]  bcast_tag;
    logic [data_w-1:0] bcast_data;

    // a tag is pending while issued_cnt is one ahead of seen_cnt
    logic [data_w-1:0] expected   [num_tags];
    int                issued_cnt [num_tags] = '{default: 0};
    int                seen_cnt   [num_tags] = '{default: 0};
    op_e               op_of      [num_tags];
    int                dep1_of    [num_tags];
    int                dep2_of    [num_tags];
    logic [data_w-1:0] val1_of    [num_tags];
    logic [data_w-1:0] val2_of    [num_tags];

    integer seed;
    int     next_tag = 0;

    issue_core dut_i (
        .clk             (clk),
        .rst             (rst),
        .disp_valid      (disp_valid),
        .disp_op         (disp_op),
        .disp_tag        (disp_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_data  (disp_src1_data),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_data  (disp_src2_data),
        .disp_full       (disp_full),
        .bcast_valid     (bcast_valid),
        .bcast_tag       (bcast_tag),
        .bcast_data      (bcast_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    function automatic logic [data_w-1:0] expected_result(input op_e op,
                                                          input logic [data_w-1:0] a,
                                                          input logic [data_w-1:0] b);
        logic [2*data_w-1:0] prod;
        prod = {{data_w{1'b0}}, a} * {{data_w{1'b0}}, b};
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_xor:  return a ^ b;
            op_mul:  return prod[data_w-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic logic [data_w-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[data_w-1:0];
    endfunction

    function automatic logic tag_pending(input int t);
        if (t < 0) begin
            return 1'b0;
        end
        return issued_cnt[t] != seen_cnt[t];
    endfunction

    function automatic logic any_pending();
        for (int k = 0; k < num_tags; k++) begin
            if (tag_pending(k)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic idle_cycle();
        @(negedge clk);
        disp_valid = 1'b0;
    endtask

    // sources wait on their producer only while it is still outstanding
    task automatic drive_op(input int t);
        disp_valid      = 1'b1;
        disp_op         = op_of[t];
        disp_tag        = tag_w'(t);
        disp_src1_ready = !tag_pending(dep1_of[t]);
        disp_src1_tag   = tag_w'(dep1_of[t]);
        disp_src1_data  = val1_of[t];
        disp_src2_ready = !tag_pending(dep2_of[t]);
        disp_src2_tag   = tag_w'(dep2_of[t]);
        disp_src2_data  = val2_of[t];
    endtask

    // a dep of -1 means the literal value is used
    task automatic reserve(input op_e op, input int d1, input logic [data_w-1:0] v1,
                           input int d2, input logic [data_w-1:0] v2, output int t);
        int found;
        found = -1;
        while (found < 0) begin
            for (int k = 0; k < num_tags; k++) begin
                if (found < 0 && !tag_pending((next_tag + k) % num_tags)) begin
                    found = (next_tag + k) % num_tags;
                end
            end
            if (found < 0) begin
                idle_cycle();
            end
        end
        t = found;
        next_tag = (found + 1) % num_tags;
        op_of[t]   = op;
        dep1_of[t] = d1;
        dep2_of[t] = d2;
        val1_of[t] = (d1 >= 0) ? expected[d1] : v1;
        val2_of[t] = (d2 >= 0) ? expected[d2] : v2;
        expected[t] = expected_result(op, val1_of[t], val2_of[t]);
        issued_cnt[t] = issued_cnt[t] + 1;
    endtask

    // leaves disp_valid high for the coming edge
    task automatic send(input int t);
        @(negedge clk);
        drive_op(t);
        #(clk_period / 4);
        while (disp_full) begin
            @(negedge clk);
            drive_op(t);
            #(clk_period / 4);
        end
    endtask

    task automatic drain();
        idle_cycle();
        while (any_pending()) begin
            idle_cycle();
        end
    endtask

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clk);
        report_failure("watchdog expired with results still outstanding");
    end

    initial begin : compare_results
        forever begin
            @(negedge clk);
            if (!rst && bcast_valid) begin
                if (issued_cnt[bcast_tag] != seen_cnt[bcast_tag] + 1) begin
                    report_failure($sformatf("tag %0d broadcast at %0t with nothing pending",
                                             bcast_tag, $time));
                end
                check_value("bcast_data", 32'(bcast_data), 32'(expected[bcast_tag]));
                seen_cnt[bcast_tag] = seen_cnt[bcast_tag] + 1;
            end
        end
    end

    initial begin : stimulus
        int               t;
        int               prev;
        int               m;
        int               d1;
        int               w [5];
        op_e              op;
        logic [data_w-1:0] r;
        seed            = 73116;
        rst             = 1'b1;
        disp_valid      = 1'b0;
        disp_op         = op_add;
        disp_tag        = '0;
        disp_src1_ready = 1'b0;
        disp_src1_tag   = '0;
        disp_src1_data  = '0;
        disp_src2_ready = 1'b0;
        disp_src2_tag   = '0;
        disp_src2_data  = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // quiet outputs after reset
        repeat (20) begin
            @(negedge clk);
            check_value("bcast_valid", 32'(bcast_valid), 32'd0);
            check_value("disp_full", 32'(disp_full), 32'd0);
        end

        for (int i = 0; i < alu_ops; i++) begin
            reserve(op_e'(3'(i % 4)), -1, rand_word(), -1, rand_word(), t);
            send(t);
        end
        drain();

        // back to back so two products are in flight
        for (int i = 0; i < mul_ops; i++) begin
            reserve(op_mul, -1, rand_word(), -1, rand_word(), t);
            send(t);
        end
        drain();

        // alu -> mul -> alu -> mul chains
        for (int i = 0; i < chain_ops / 4; i++) begin
            reserve(op_add, -1, rand_word(), -1, rand_word(), prev);
            send(prev);
            reserve(op_mul, prev, '0, -1, rand_word(), m);
            send(m);
            reserve(op_sub, m, '0, prev, '0, t);
            send(t);
            reserve(op_mul, t, '0, t, '0, m);
            send(m);
        end
        drain();

        // five alu ops all waiting on a multiply that is sent last
        reserve(op_mul, -1, rand_word(), -1, rand_word(), m);
        for (int k = 0; k < 5; k++) begin
            reserve(op_e'(3'(k % 4)), m, '0, -1, rand_word(), w[k]);
        end
        for (int k = 0; k < 4; k++) begin
            send(w[k]);
        end
        @(negedge clk);
        drive_op(w[4]);
        #(clk_period / 4);
        check_value("disp_full", 32'(disp_full), 32'd1);
        send(m);
        send(w[4]);
        drain();

        // mixed stream keeping both units and the bus busy
        prev = -1;
        for (int i = 0; i < mix_ops; i++) begin
            r = rand_word();
            if (r[0]) begin
                op = op_mul;
            end else begin
                op = op_e'({1'b0, r[2:1]});
            end
            d1 = (r[3] && prev >= 0) ? prev : -1;
            reserve(op, d1, rand_word(), -1, rand_word(), t);
            send(t);
            prev = t;
        end
        drain();

        $display("sim passed");
        $finish;
    end

endmodule

/* hw/issue_core.sv */
`timescale 1ns/1ps

module issue_core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          disp_valid,
    input  issue_pkg::op_e                disp_op,
    input  logic [issue_pkg::tag_w-1:0]   disp_tag,
    input  logic                          disp_src1_ready,
    input  logic [issue_pkg::tag_w-1:0]   disp_src1_tag,
    input  logic [issue_pkg::data_w-1:0]  disp_src1_data,
    input  logic                          disp_src2_ready,
    input  logic [issue_pkg::tag_w-1:0]   disp_src2_tag,
    input  logic [issue_pkg::data_w-1:0]  disp_src2_data,
    output logic                          disp_full,
    output logic                          bcast_valid,
    output logic [issue_pkg::tag_w-1:0]   bcast_tag,
    output logic [issue_pkg::data_w-1:0]  bcast_data
);
    import issue_pkg::*;

    logic              disp_is_mul;
    logic              alu_wr;
    logic              mul_wr;
    logic              alu_full;
    logic              mul_full;

    logic              alu_iss_valid;
    op_e               alu_iss_op;
    logic [tag_w-1:0]  alu_iss_tag;
    logic [data_w-1:0] alu_iss_a;
    logic [data_w-1:0] alu_iss_b;
    logic              mul_iss_valid;
    logic [tag_w-1:0]  mul_iss_tag;
    logic [data_w-1:0] mul_iss_a;
    logic [data_w-1:0] mul_iss_b;

    logic              alu_ready;
    logic              alu_res_valid;
    logic [tag_w-1:0]  alu_res_tag;
    logic [data_w-1:0] alu_res_data;
    logic              alu_grant;
    logic              mul_ready;
    logic              mul_res_valid;
    logic [tag_w-1:0]  mul_res_tag;
    logic [data_w-1:0] mul_res_data;
    logic              mul_grant;

    // steer by opcode
    assign disp_is_mul = (disp_op == op_mul);
    assign alu_wr      = disp_valid && !disp_is_mul;
    assign mul_wr      = disp_valid && disp_is_mul;
    assign disp_full   = disp_is_mul ? mul_full : alu_full;

    issue_queue #(
        .queue_len (alu_queue_len),
        .kind      (unit_alu)
    ) alu_queue_i (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (alu_wr),
        .wr_op         (disp_op),
        .wr_tag        (disp_tag),
        .wr_src1_ready (disp_src1_ready),
        .wr_src1_tag   (disp_src1_tag),
        .wr_src1_data  (disp_src1_data),
        .wr_src2_ready (disp_src2_ready),
        .wr_src2_tag   (disp_src2_tag),
        .wr_src2_data  (disp_src2_data),
        .bcast_valid   (bcast_valid),
        .bcast_tag     (bcast_tag),
        .bcast_data    (bcast_data),
        .unit_ready    (alu_ready),
        .full          (alu_full),
        .issue_valid   (alu_iss_valid),
        .issue_op      (alu_iss_op),
        .issue_tag     (alu_iss_tag),
        .issue_a       (alu_iss_a),
        .issue_b       (alu_iss_b)
    );

    // the multiplier needs no opcode
    issue_queue #(
        .queue_len (mul_queue_len),
        .kind      (unit_mul)
    ) mul_queue_i (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (mul_wr),
        .wr_op         (disp_op),
        .wr_tag        (disp_tag),
        .wr_src1_ready (disp_src1_ready),
        .wr_src1_tag   (disp_src1_tag),
        .wr_src1_data  (disp_src1_data),
        .wr_src2_ready (disp_src2_ready),
        .wr_src2_tag   (disp_src2_tag),
        .wr_src2_data  (disp_src2_data),
        .bcast_valid   (bcast_valid),
        .bcast_tag     (bcast_tag),
        .bcast_data    (bcast_data),
        .unit_ready    (mul_ready),
        .full          (mul_full),
        .issue_valid   (mul_iss_valid),
        .issue_op      (),
        .issue_tag     (mul_iss_tag),
        .issue_a       (mul_iss_a),
        .issue_b       (mul_iss_b)
    );

    alu_unit alu_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (alu_iss_valid),
        .in_op     (alu_iss_op),
        .in_tag    (alu_iss_tag),
        .in_a      (alu_iss_a),
        .in_b      (alu_iss_b),
        .grant     (alu_grant),
        .ready     (alu_ready),
        .res_valid (alu_res_valid),
        .res_tag   (alu_res_tag),
        .res_data  (alu_res_data)
    );

    mul_unit mul_unit_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_iss_valid),
        .in_tag    (mul_iss_tag),
        .in_a      (mul_iss_a),
        .in_b      (mul_iss_b),
        .grant     (mul_grant),
        .ready     (mul_ready),
        .res_valid (mul_res_valid),
        .res_tag   (mul_res_tag),
        .res_data  (mul_res_data)
    );

    result_arbiter result_arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .alu_req     (alu_res_valid),
        .alu_tag     (alu_res_tag),
        .alu_data    (alu_res_data),
        .mul_req     (mul_res_valid),
        .mul_tag     (mul_res_tag),
        .mul_data    (mul_res_data),
        .alu_grant   (alu_grant),
        .mul_grant   (mul_grant),
        .bcast_valid (bcast_valid),
        .bcast_tag   (bcast_tag),
        .bcast_data  (bcast_data)
    );

endmodule

/* hw/result_arbiter.sv */
`timescale 1ns/1ps

module result_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alu_req,
    input  logic [issue_pkg::tag_w-1:0]   alu_tag,
    input  logic [issue_pkg::data_w-1:0]  alu_data,
    input  logic                          mul_req,
    input  logic [issue_pkg::tag_w-1:0]   mul_tag,
    input  logic [issue_pkg::data_w-1:0]  mul_data,
    output logic                          alu_grant,
    output logic                          mul_grant,
    output logic                          bcast_valid,
    output logic [issue_pkg::tag_w-1:0]   bcast_tag,
    output logic [issue_pkg::data_w-1:0]  bcast_data
);
    import issue_pkg::*;

    unit_e last_win;

    // on conflict the unit that did not win last time goes first
    always_comb begin
        alu_grant = alu_req;
        mul_grant = mul_req;
        if (alu_req && mul_req) begin
            alu_grant = (last_win == unit_mul);
            mul_grant = (last_win == unit_alu);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= unit_mul;
        end else if (alu_grant) begin
            last_win <= unit_alu;
        end else if (mul_grant) begin
            last_win <= unit_mul;
        end
    end

    assign bcast_valid = alu_grant || mul_grant;
    assign bcast_tag   = mul_grant ? mul_tag : alu_tag;
    assign bcast_data  = mul_grant ? mul_data : alu_data;

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [issue_pkg::tag_w-1:0]   in_tag,
    input  logic [issue_pkg::data_w-1:0]  in_a,
    input  logic [issue_pkg::data_w-1:0]  in_b,
    input  logic                          grant,
    output logic                          ready,
    output logic                          res_valid,
    output logic [issue_pkg::tag_w-1:0]   res_tag,
    output logic [issue_pkg::data_w-1:0]  res_data
);
    import issue_pkg::*;

    logic              s1_valid;
    logic [tag_w-1:0]  s1_tag;
    logic [data_w-1:0] s1_a;
    logic [data_w-1:0] s1_b;
    logic [data_w-1:0] s1_prod;
    logic              advance;

    // low half of the product only
    assign s1_prod = s1_a * s1_b;

    // whole pipe moves together, held while the last stage waits for the bus
    assign advance = !res_valid || grant;
    assign ready   = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= in_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            s1_tag <= in_tag;
            s1_a   <= in_a;
            s1_b   <= in_b;
        end
        if (advance && s1_valid) begin
            res_tag  <= s1_tag;
            res_data <= s1_prod;
        end
    end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  issue_pkg::op_e                in_op,
    input  logic [issue_pkg::tag_w-1:0]   in_tag,
    input  logic [issue_pkg::data_w-1:0]  in_a,
    input  logic [issue_pkg::data_w-1:0]  in_b,
    input  logic                          grant,
    output logic                          ready,
    output logic                          res_valid,
    output logic [issue_pkg::tag_w-1:0]   res_tag,
    output logic [issue_pkg::data_w-1:0]  res_data
);
    import issue_pkg::*;

    logic [data_w-1:0] alu_out;

    always_comb begin
        case (in_op)
            op_add:  alu_out = in_a + in_b;
            op_sub:  alu_out = in_a - in_b;
            op_and:  alu_out = in_a & in_b;
            op_xor:  alu_out = in_a ^ in_b;
            default: alu_out = '0;
        endcase
    end

    // result register is free when empty or leaving on this grant
    assign ready = !res_valid || grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (ready) begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && in_valid) begin
            res_tag  <= in_tag;
            res_data <= alu_out;
        end
    end

endmodule

/* hw/issue_queue.sv */
`timescale 1ns/1ps

module issue_queue #(
    parameter int               queue_len = issue_pkg::alu_queue_len,
    parameter issue_pkg::unit_e kind      = issue_pkg::unit_alu
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_valid,
    input  issue_pkg::op_e                wr_op,
    input  logic [issue_pkg::tag_w-1:0]   wr_tag,
    input  logic                          wr_src1_ready,
    input  logic [issue_pkg::tag_w-1:0]   wr_src1_tag,
    input  logic [issue_pkg::data_w-1:0]  wr_src1_data,
    input  logic                          wr_src2_ready,
    input  logic [issue_pkg::tag_w-1:0]   wr_src2_tag,
    input  logic [issue_pkg::data_w-1:0]  wr_src2_data,
    input  logic                          bcast_valid,
    input  logic [issue_pkg::tag_w-1:0]   bcast_tag,
    input  logic [issue_pkg::data_w-1:0]  bcast_data,
    input  logic                          unit_ready,
    output logic                          full,
    output logic                          issue_valid,
    output issue_pkg::op_e                issue_op,
    output logic [issue_pkg::tag_w-1:0]   issue_tag,
    output logic [issue_pkg::data_w-1:0]  issue_a,
    output logic [issue_pkg::data_w-1:0]  issue_b
);
    import issue_pkg::*;

    localparam int idx_w = $clog2(queue_len);
    localparam int cnt_w = $clog2(queue_len + 1);

    // entry 0 is the oldest, count entries are live
    op_e               q_op      [queue_len];
    logic [tag_w-1:0]  q_tag     [queue_len];
    logic              q_s1_rdy  [queue_len];
    logic [tag_w-1:0]  q_s1_tag  [queue_len];
    logic [data_w-1:0] q_s1_data [queue_len];
    logic              q_s2_rdy  [queue_len];
    logic [tag_w-1:0]  q_s2_tag  [queue_len];
    logic [data_w-1:0] q_s2_data [queue_len];
    logic [cnt_w-1:0]  count;

    logic              w_s1_rdy  [queue_len];
    logic [data_w-1:0] w_s1_data [queue_len];
    logic              w_s2_rdy  [queue_len];
    logic [data_w-1:0] w_s2_data [queue_len];

    op_e               n_op      [queue_len];
    logic [tag_w-1:0]  n_tag     [queue_len];
    logic              n_s1_rdy  [queue_len];
    logic [tag_w-1:0]  n_s1_tag  [queue_len];
    logic [data_w-1:0] n_s1_data [queue_len];
    logic              n_s2_rdy  [queue_len];
    logic [tag_w-1:0]  n_s2_tag  [queue_len];
    logic [data_w-1:0] n_s2_data [queue_len];
    logic [cnt_w-1:0]  mid_count;
    logic [cnt_w-1:0]  n_count;

    logic              wr_ours;
    logic              in_s1_wake;
    logic              in_s2_wake;
    logic              in_s1_rdy;
    logic              in_s2_rdy;
    logic [data_w-1:0] in_s1_data;
    logic [data_w-1:0] in_s2_data;
    logic              sel_found;
    logic [idx_w-1:0]  sel_idx;
    logic              issue_ok;
    logic              bypass;
    logic              append;

    // ignore writes meant for the other unit
    assign wr_ours = wr_valid && ((wr_op == op_mul) == (kind == unit_mul));

    // wakeup of the incoming write
    assign in_s1_wake = bcast_valid && !wr_src1_ready && (wr_src1_tag == bcast_tag);
    assign in_s2_wake = bcast_valid && !wr_src2_ready && (wr_src2_tag == bcast_tag);
    assign in_s1_rdy  = wr_src1_ready || in_s1_wake;
    assign in_s2_rdy  = wr_src2_ready || in_s2_wake;
    assign in_s1_data = in_s1_wake ? bcast_data : wr_src1_data;
    assign in_s2_data = in_s2_wake ? bcast_data : wr_src2_data;

    // wakeup of stored entries, then oldest-ready select
    always_comb begin
        for (int i = 0; i < queue_len; i++) begin
            w_s1_rdy[i]  = q_s1_rdy[i];
            w_s1_data[i] = q_s1_data[i];
            w_s2_rdy[i]  = q_s2_rdy[i];
            w_s2_data[i] = q_s2_data[i];
            if (bcast_valid && !q_s1_rdy[i] && (q_s1_tag[i] == bcast_tag)) begin
                w_s1_rdy[i]  = 1'b1;
                w_s1_data[i] = bcast_data;
            end
            if (bcast_valid && !q_s2_rdy[i] && (q_s2_tag[i] == bcast_tag)) begin
                w_s2_rdy[i]  = 1'b1;
                w_s2_data[i] = bcast_data;
            end
        end
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = queue_len - 1; i >= 0; i--) begin
            if ((i < int'(count)) && w_s1_rdy[i] && w_s2_rdy[i]) begin
                sel_found = 1'b1;
                sel_idx   = idx_w'(i);
            end
        end
    end

    assign issue_ok  = unit_ready && sel_found;
    assign mid_count = count - cnt_w'(issue_ok);
    // bypass only when the queue has nothing older to send
    assign bypass    = wr_ours && unit_ready && !sel_found && in_s1_rdy && in_s2_rdy;
    assign append    = wr_ours && !bypass && (mid_count != cnt_w'(queue_len));
    assign full      = wr_ours && !bypass && (mid_count == cnt_w'(queue_len));
    assign n_count   = mid_count + cnt_w'(append);

    always_comb begin
        for (int i = 0; i < queue_len; i++) begin
            n_op[i]      = q_op[i];
            n_tag[i]     = q_tag[i];
            n_s1_rdy[i]  = w_s1_rdy[i];
            n_s1_tag[i]  = q_s1_tag[i];
            n_s1_data[i] = w_s1_data[i];
            n_s2_rdy[i]  = w_s2_rdy[i];
            n_s2_tag[i]  = q_s2_tag[i];
            n_s2_data[i] = w_s2_data[i];
        end
        // close the hole left by the issued entry
        if (issue_ok) begin
            for (int i = 0; i < queue_len - 1; i++) begin
                if (i >= int'(sel_idx)) begin
                    n_op[i]      = n_op[i+1];
                    n_tag[i]     = n_tag[i+1];
                    n_s1_rdy[i]  = n_s1_rdy[i+1];
                    n_s1_tag[i]  = n_s1_tag[i+1];
                    n_s1_data[i] = n_s1_data[i+1];
                    n_s2_rdy[i]  = n_s2_rdy[i+1];
                    n_s2_tag[i]  = n_s2_tag[i+1];
                    n_s2_data[i] = n_s2_data[i+1];
                end
            end
        end
        for (int i = 0; i < queue_len; i++) begin
            if (append && (i == int'(mid_count))) begin
                n_op[i]      = wr_op;
                n_tag[i]     = wr_tag;
                n_s1_rdy[i]  = in_s1_rdy;
                n_s1_tag[i]  = wr_src1_tag;
                n_s1_data[i] = in_s1_data;
                n_s2_rdy[i]  = in_s2_rdy;
                n_s2_tag[i]  = wr_src2_tag;
                n_s2_data[i] = in_s2_data;
            end
        end
    end

    always_comb begin
        issue_valid = issue_ok || bypass;
        if (issue_ok) begin
            issue_op  = q_op[sel_idx];
            issue_tag = q_tag[sel_idx];
            issue_a   = w_s1_data[sel_idx];
            issue_b   = w_s2_data[sel_idx];
        end else begin
            issue_op  = wr_op;
            issue_tag = wr_tag;
            issue_a   = in_s1_data;
            issue_b   = in_s2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= n_count;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < queue_len; i++) begin
            q_op[i]      <= n_op[i];
            q_tag[i]     <= n_tag[i];
            q_s1_rdy[i]  <= n_s1_rdy[i];
            q_s1_tag[i]  <= n_s1_tag[i];
            q_s1_data[i] <= n_s1_data[i];
            q_s2_rdy[i]  <= n_s2_rdy[i];
            q_s2_tag[i]  <= n_s2_tag[i];
            q_s2_data[i] <= n_s2_data[i];
        end
    end

endmodule

/* hw/issue_pkg.sv */
package issue_pkg;

    // tag space shared by dispatch, queues and broadcast bus
    localparam int tag_w = 4;

    // operand and result width
    localparam int data_w = 16;

    // queue depths
    localparam int alu_queue_len = 4;
    localparam int mul_queue_len = 4;

    // opcodes; op_mul is the only one steered to the multiplier
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul
    } op_e;

    // execution unit behind a queue
    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

endpackage
